/* hdl/cpu_defines.svh */
////////////////////
// CPU constants
// Widths, opcodes, ALU function codes and forwarding selects for the
// five-stage integer pipeline
////////////////////
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_IMM_W       17

// Opcodes in bits 31..27
`define CPU_OP_RTYPE    5'd0
`define CPU_OP_J        5'd1
`define CPU_OP_BNE      5'd2
`define CPU_OP_JAL      5'd3
`define CPU_OP_ADDI     5'd5
`define CPU_OP_BLT      5'd6
`define CPU_OP_SW       5'd7
`define CPU_OP_LW       5'd8

// R-type function in bits 6..2
`define CPU_ALU_ADD     5'd0
`define CPU_ALU_SUB     5'd1
`define CPU_ALU_AND     5'd2
`define CPU_ALU_OR      5'd3
`define CPU_ALU_SLL     5'd4
`define CPU_ALU_SRA     5'd5

`define CPU_LINK_REG    5'd31

// Execute operand source
`define CPU_FWD_NONE    2'd0
`define CPU_FWD_MEM     2'd1
`define CPU_FWD_WB      2'd2

`endif

/* hdl/cpu_pkg.sv */
////////////////////
// CPU package
// Word and field types, pipeline register layouts and field decoders
////////////////////
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]       word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]                 opcode_t;
    typedef logic [4:0]                 alu_op_t;

    // All-zero value of every stage register is a bubble
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fd_reg_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t a_val;
        word_t b_val;
    } dx_reg_t;

    typedef struct packed {
        opcode_t   op;
        reg_addr_t rd;
        reg_addr_t rs;
        word_t     result;
        word_t     store_val;
        logic      wr_en;
        logic      is_load;
    } xm_reg_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t rd;
        word_t     result;
    } mw_reg_t;

    function automatic opcode_t op_of(word_t instr);
        return instr[31:27];
    endfunction

    function automatic reg_addr_t rd_of(word_t instr);
        return instr[26:22];
    endfunction

    function automatic reg_addr_t rs_of(word_t instr);
        return instr[21:17];
    endfunction

    function automatic reg_addr_t rt_of(word_t instr);
        return instr[16:12];
    endfunction

    // Port B carries rt for R-type, rd for everything else
    function automatic reg_addr_t port_b_of(word_t instr);
        return (op_of(instr) == `CPU_OP_RTYPE) ? rt_of(instr) : rd_of(instr);
    endfunction

endpackage

/* hdl/reg_file.sv */
////////////////////
// Register file
// 32 x 32-bit, two read ports, one write port, r0 fixed at zero,
// reads bypass the value being written this cycle
////////////////////
module reg_file
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  mw_reg_t   wb
);

    word_t regs [1:31];
    logic  wr_live;
    logic  hit_a;
    logic  hit_b;

    assign wr_live = wb.wr_en && (wb.rd != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // Write-through so decode sees the retiring value
    assign hit_a = wr_live && (wb.rd == rd_addr_a);
    assign hit_b = wr_live && (wb.rd == rd_addr_b);

    assign rd_data_a = (rd_addr_a == '0) ? '0 : hit_a ? wb.result : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : hit_b ? wb.result : regs[rd_addr_b];

endmodule

/* hdl/fetch_stage.sv */
////////////////////
// Fetch stage
// Program counter, next-PC choice and the fetch/decode register
////////////////////
module fetch_stage
    import cpu_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    stall,
    input  logic    redirect,
    input  word_t   redirect_pc,
    output word_t   address_imem,
    input  word_t   q_imem,
    output fd_reg_t fd
);

    word_t pc;
    word_t pc_next;

    // Redirect wins over stall
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    assign address_imem = pc;

    always_ff @(posedge clock) begin
        if (reset || redirect) begin
            fd <= '0;
        end else if (!stall) begin
            fd.pc    <= pc;
            fd.instr <= q_imem;
        end
    end

endmodule

/* hdl/decode_stage.sv */
////////////////////
// Decode stage
// Register read addressing and the decode/execute register
////////////////////
`include "cpu_defines.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      stall,
    input  logic      redirect,
    input  fd_reg_t   fd,
    output reg_addr_t rd_addr_a,
    output reg_addr_t rd_addr_b,
    input  word_t     rd_data_a,
    input  word_t     rd_data_b,
    output dx_reg_t   dx
);

    logic    insert_bubble;
    dx_reg_t dx_next;

    // Port A is always rs; stores and branches read rd on port B
    assign rd_addr_a = rs_of(fd.instr);
    assign rd_addr_b = port_b_of(fd.instr);

    assign insert_bubble = stall || redirect;

    always_comb begin
        dx_next.pc    = fd.pc;
        dx_next.instr = fd.instr;
        dx_next.a_val = rd_data_a;
        dx_next.b_val = rd_data_b;
    end

    always_ff @(posedge clock) begin
        if (reset || insert_bubble) begin
            dx <= '0;
        end else begin
            dx <= dx_next;
        end
    end

endmodule

/* hdl/hazard_unit.sv */
////////////////////
// Hazard unit
// Operand forwarding selects for execute and load-use stall detection
////////////////////
`include "cpu_defines.svh"

module hazard_unit
    import cpu_pkg::*;
(
    input  fd_reg_t    fd,
    input  dx_reg_t    dx,
    input  xm_reg_t    xm,
    input  mw_reg_t    mw,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       stall
);

    opcode_t   dec_op;
    reg_addr_t load_rd;
    logic      load_in_ex;
    logic      dec_uses_rs;
    logic      dec_uses_rt;
    logic      dec_uses_rd;

    // Nearest producer wins
    function automatic logic [1:0] fwd_sel(reg_addr_t src, xm_reg_t m, mw_reg_t w);
        if (m.wr_en && (m.rd != '0) && (m.rd == src)) begin
            return `CPU_FWD_MEM;
        end else if (w.wr_en && (w.rd != '0) && (w.rd == src)) begin
            return `CPU_FWD_WB;
        end
        return `CPU_FWD_NONE;
    endfunction

    assign fwd_a = fwd_sel(rs_of(dx.instr), xm, mw);
    assign fwd_b = fwd_sel(port_b_of(dx.instr), xm, mw);

    // Which registers the instruction in decode really reads
    assign dec_op      = op_of(fd.instr);
    assign dec_uses_rt = (dec_op == `CPU_OP_RTYPE);
    assign dec_uses_rd = (dec_op == `CPU_OP_SW) || (dec_op == `CPU_OP_BNE)
                      || (dec_op == `CPU_OP_BLT);
    assign dec_uses_rs = dec_uses_rt || dec_uses_rd
                      || (dec_op == `CPU_OP_ADDI) || (dec_op == `CPU_OP_LW);

    assign load_rd    = rd_of(dx.instr);
    assign load_in_ex = (op_of(dx.instr) == `CPU_OP_LW) && (load_rd != '0);

    // Load data is not ready until writeback, so hold decode one cycle
    assign stall = load_in_ex && (
                       (dec_uses_rs && (rs_of(fd.instr) == load_rd))
                    || (dec_uses_rt && (rt_of(fd.instr) == load_rd))
                    || (dec_uses_rd && (rd_of(fd.instr) == load_rd)));

endmodule

/* hdl/execute_stage.sv */
////////////////////
// Execute stage
// Forwarding muxes, ALU, branch and jump resolution, jal link write
// and the execute/memory register
////////////////////
`include "cpu_defines.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic       clock,
    input  logic       reset,
    input  dx_reg_t    dx,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  word_t      fwd_mem,
    input  word_t      fwd_wb,
    output logic       redirect,
    output word_t      redirect_pc,
    output xm_reg_t    xm
);

    opcode_t    op;
    reg_addr_t  rd;
    logic [4:0] shamt;
    word_t      imm_ext;
    word_t      pc_plus1;
    word_t      op_a;
    word_t      op_b;
    alu_op_t    alu_op;
    word_t      alu_b;
    word_t      alu_y;
    logic       is_rtype;
    logic       is_jal;
    logic       is_jump;
    logic       is_load;
    logic       branch_taken;
    logic       writes_rd;
    xm_reg_t    xm_next;

    assign op       = op_of(dx.instr);
    assign rd       = rd_of(dx.instr);
    assign shamt    = dx.instr[11:7];
    assign imm_ext  = {{(`CPU_XLEN-`CPU_IMM_W){dx.instr[`CPU_IMM_W-1]}},
                       dx.instr[`CPU_IMM_W-1:0]};
    assign pc_plus1 = dx.pc + 1'b1;

    assign is_rtype = (op == `CPU_OP_RTYPE);
    assign is_jal   = (op == `CPU_OP_JAL);
    assign is_jump  = is_jal || (op == `CPU_OP_J);
    assign is_load  = (op == `CPU_OP_LW);

    // Bypass from the memory or writeback stage
    always_comb begin
        case (fwd_a)
            `CPU_FWD_MEM: op_a = fwd_mem;
            `CPU_FWD_WB:  op_a = fwd_wb;
            default:      op_a = dx.a_val;
        endcase
        case (fwd_b)
            `CPU_FWD_MEM: op_b = fwd_mem;
            `CPU_FWD_WB:  op_b = fwd_wb;
            default:      op_b = dx.b_val;
        endcase
    end

    // addi, lw and sw all compute rs + imm
    assign alu_op = is_rtype ? dx.instr[6:2] : `CPU_ALU_ADD;
    assign alu_b  = is_rtype ? op_b : imm_ext;

    always_comb begin
        case (alu_op)
            `CPU_ALU_SUB: alu_y = op_a - alu_b;
            `CPU_ALU_AND: alu_y = op_a & alu_b;
            `CPU_ALU_OR:  alu_y = op_a | alu_b;
            `CPU_ALU_SLL: alu_y = op_a << shamt;
            `CPU_ALU_SRA: alu_y = $signed(op_a) >>> shamt;
            default:      alu_y = op_a + alu_b;
        endcase
    end

    // Branches compare rd (port B) against rs (port A)
    always_comb begin
        case (op)
            `CPU_OP_BNE: branch_taken = (op_b != op_a);
            `CPU_OP_BLT: branch_taken = ($signed(op_b) < $signed(op_a));
            default:     branch_taken = 1'b0;
        endcase
    end

    assign redirect    = branch_taken || is_jump;
    assign redirect_pc = is_jump ? {{(`CPU_XLEN-27){1'b0}}, dx.instr[26:0]}
                                 : pc_plus1 + imm_ext;

    assign writes_rd = (is_rtype || is_load || (op == `CPU_OP_ADDI)) && (rd != '0);

    always_comb begin
        xm_next.op        = op;
        xm_next.rd        = is_jal ? `CPU_LINK_REG : rd;
        xm_next.rs        = rs_of(dx.instr);
        xm_next.result    = is_jal ? pc_plus1 : alu_y;
        xm_next.store_val = op_b;
        xm_next.wr_en     = writes_rd || is_jal;
        xm_next.is_load   = is_load;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            xm <= '0;
        end else begin
            xm <= xm_next;
        end
    end

endmodule

/* hdl/memory_stage.sv */
////////////////////
// Memory stage
// Data memory access, store data bypass and the memory/writeback register
////////////////////
`include "cpu_defines.svh"

module memory_stage
    import cpu_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  xm_reg_t xm,
    input  word_t   wb_result,
    output word_t   address_dmem,
    output word_t   data,
    output logic    wren,
    input  word_t   q_dmem,
    output mw_reg_t mw
);

    logic is_store;
    logic store_fwd;

    assign is_store     = (xm.op == `CPU_OP_SW);
    assign address_dmem = xm.result;
    assign wren         = is_store;

    // Store source register being written back right now
    assign store_fwd = is_store && mw.wr_en && (mw.rd != '0) && (mw.rd == xm.rd);
    assign data      = store_fwd ? wb_result : xm.store_val;

    always_ff @(posedge clock) begin
        if (reset) begin
            mw <= '0;
        end else begin
            mw.wr_en  <= xm.wr_en;
            mw.rd     <= xm.rd;
            mw.result <= xm.is_load ? q_dmem : xm.result;
        end
    end

endmodule

/* hdl/pipeline_cpu.sv */
////////////////////
// Pipelined CPU top
// Five-stage integer core with forwarding, load-use stall and
// branch flush; memories sit outside
////////////////////
module pipeline_cpu
    import cpu_pkg::*;
(
    input  logic  clock,
    input  logic  reset,
    output word_t address_imem,
    input  word_t q_imem,
    output word_t address_dmem,
    output word_t data,
    output logic  wren,
    input  word_t q_dmem
);

    fd_reg_t    fd;
    dx_reg_t    dx;
    xm_reg_t    xm;
    mw_reg_t    mw;
    logic       stall;
    logic       redirect;
    word_t      redirect_pc;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    reg_addr_t  rd_addr_a;
    reg_addr_t  rd_addr_b;
    word_t      rd_data_a;
    word_t      rd_data_b;

    fetch_stage u_fetch (
        .clock        (clock),
        .reset        (reset),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .fd           (fd)
    );

    decode_stage u_decode (
        .clock     (clock),
        .reset     (reset),
        .stall     (stall),
        .redirect  (redirect),
        .fd        (fd),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .dx        (dx)
    );

    reg_file u_reg_file (
        .clock     (clock),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wb        (mw)
    );

    hazard_unit u_hazard (
        .fd    (fd),
        .dx    (dx),
        .xm    (xm),
        .mw    (mw),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b),
        .stall (stall)
    );

    execute_stage u_execute (
        .clock       (clock),
        .reset       (reset),
        .dx          (dx),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .fwd_mem     (xm.result),
        .fwd_wb      (mw.result),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm          (xm)
    );

    memory_stage u_memory (
        .clock        (clock),
        .reset        (reset),
        .xm           (xm),
        .wb_result    (mw.result),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem),
        .mw           (mw)
    );

endmodule

/* tb/cpu_clock_gen.sv */
////////////////////
// Testbench clock
// Free-running clock of period 8 and a power-on reset for 3 cycles
////////////////////
module cpu_clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
    end

endmodule

/* tb/cpu_programs.svh */
////////////////////
// Test program table
// One entry per program, each with its instruction words and the
// address/data pairs it must store, in order
////////////////////
localparam int NUM_ENTRIES = 4;

task automatic load_entry(input int idx);
    logic [16:0] imm_a;
    logic [16:0] imm_b;
    logic [4:0]  sh_a;
    logic [4:0]  sh_b;
    word_t       r1, r2, r3, r4, r5, r6, r7, r8;
    case (idx)
        0: begin
            // Dependent ALU chain with random immediates and shift amounts
            test_name = "alu_chain";
            rng_state = xorshift32(rng_state);
            imm_a     = rng_state[16:0];
            rng_state = xorshift32(rng_state);
            imm_b     = rng_state[16:0];
            rng_state = xorshift32(rng_state);
            sh_a      = rng_state[4:0];
            sh_b      = rng_state[12:8];
            emit(i_type(`CPU_OP_ADDI, 1, 0, imm_a));
            emit(i_type(`CPU_OP_ADDI, 2, 1, imm_b));
            emit(r_type(`CPU_ALU_ADD, 3, 1, 2, 0));
            emit(r_type(`CPU_ALU_SUB, 4, 3, 1, 0));
            emit(r_type(`CPU_ALU_AND, 5, 4, 3, 0));
            emit(r_type(`CPU_ALU_OR, 6, 5, 2, 0));
            emit(r_type(`CPU_ALU_SLL, 7, 6, 0, sh_a));
            emit(r_type(`CPU_ALU_SRA, 8, 7, 0, sh_b));
            emit(i_type(`CPU_OP_SW, 8, 0, 16));
            emit(i_type(`CPU_OP_SW, 7, 0, 17));
            emit(i_type(`CPU_OP_SW, 6, 0, 18));
            emit(i_type(`CPU_OP_SW, 5, 0, 19));
            emit(i_type(`CPU_OP_SW, 4, 0, 20));
            emit(i_type(`CPU_OP_SW, 3, 0, 21));
            emit(i_type(`CPU_OP_SW, 2, 0, 22));
            emit(i_type(`CPU_OP_SW, 1, 0, 23));
            emit(j_type(`CPU_OP_J, 16));
            r1 = sext17(imm_a);
            r2 = r1 + sext17(imm_b);
            r3 = r1 + r2;
            r4 = r3 - r1;
            r5 = r4 & r3;
            r6 = r5 | r2;
            r7 = r6 << sh_a;
            r8 = $signed(r7) >>> sh_b;
            expect_store(16, r8);
            expect_store(17, r7);
            expect_store(18, r6);
            expect_store(19, r5);
            expect_store(20, r4);
            expect_store(21, r3);
            expect_store(22, r2);
            expect_store(23, r1);
        end
        1: begin
            test_name = "store_load_use";
            emit(i_type(`CPU_OP_ADDI, 1, 0, 21));
            emit(i_type(`CPU_OP_SW, 1, 0, 32));
            emit(i_type(`CPU_OP_LW, 2, 0, 32));
            emit(r_type(`CPU_ALU_ADD, 3, 2, 1, 0));
            emit(i_type(`CPU_OP_SW, 3, 0, 33));
            emit(i_type(`CPU_OP_LW, 4, 0, 33));
            emit(i_type(`CPU_OP_SW, 4, 0, 34));
            // Three apart so decode reads r5 while it is written back
            emit(i_type(`CPU_OP_LW, 5, 0, 32));
            emit(i_type(`CPU_OP_ADDI, 6, 0, 1));
            emit(i_type(`CPU_OP_ADDI, 7, 0, 2));
            emit(i_type(`CPU_OP_SW, 5, 0, 35));
            emit(j_type(`CPU_OP_J, 11));
            expect_store(32, 21);
            expect_store(33, 42);
            expect_store(34, 42);
            expect_store(35, 21);
        end
        2: begin
            test_name = "branches";
            emit(i_type(`CPU_OP_ADDI, 1, 0, 5));
            emit(i_type(`CPU_OP_ADDI, 2, 0, 9));
            emit(i_type(`CPU_OP_BNE, 1, 2, 2));
            emit(i_type(`CPU_OP_SW, 1, 0, 40));
            emit(i_type(`CPU_OP_SW, 2, 0, 41));
            emit(i_type(`CPU_OP_BNE, 1, 1, 2));
            emit(i_type(`CPU_OP_SW, 1, 0, 42));
            emit(i_type(`CPU_OP_SW, 2, 0, 43));
            emit(i_type(`CPU_OP_BLT, 1, 2, 2));
            emit(i_type(`CPU_OP_SW, 1, 0, 44));
            emit(i_type(`CPU_OP_SW, 2, 0, 45));
            emit(i_type(`CPU_OP_BLT, 2, 1, 2));
            emit(i_type(`CPU_OP_SW, 1, 0, 46));
            emit(i_type(`CPU_OP_SW, 2, 0, 47));
            // Signed compare of -3 against 5
            emit(i_type(`CPU_OP_ADDI, 3, 0, -3));
            emit(i_type(`CPU_OP_BLT, 3, 1, 2));
            emit(i_type(`CPU_OP_SW, 3, 0, 48));
            emit(i_type(`CPU_OP_SW, 3, 0, 49));
            emit(i_type(`CPU_OP_SW, 3, 0, 50));
            emit(j_type(`CPU_OP_J, 19));
            expect_store(42, 5);
            expect_store(43, 9);
            expect_store(46, 5);
            expect_store(47, 9);
            expect_store(50, 32'hffff_fffd);
        end
        3: begin
            test_name = "jal_call";
            emit(i_type(`CPU_OP_ADDI, 1, 0, 3));
            emit(j_type(`CPU_OP_JAL, 6));
            emit(i_type(`CPU_OP_SW, 1, 0, 60));
            emit(i_type(`CPU_OP_SW, 1, 0, 61));
            emit(i_type(`CPU_OP_SW, 1, 0, 62));
            emit(j_type(`CPU_OP_J, 5));
            // Subroutine at 6
            emit(i_type(`CPU_OP_SW, 31, 0, 64));
            emit(i_type(`CPU_OP_ADDI, 1, 1, 1));
            emit(j_type(`CPU_OP_J, 4));
            emit(i_type(`CPU_OP_SW, 1, 0, 65));
            emit(i_type(`CPU_OP_SW, 1, 0, 66));
            expect_store(64, 2);
            expect_store(62, 4);
        end
        default: begin
            test_name = "empty";
        end
    endcase
endtask

/* tb/cpu_tb.sv */
////////////////////
// CPU testbench
// Runs each table program on the pipelined CPU with behavioral
// memories and checks the sequence of stores
////////////////////
`include "cpu_defines.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int MEM_WORDS     = 256;
    localparam int STORE_TIMEOUT = 200;
    localparam int DRAIN_CYCLES  = 20;

    logic  clock;
    logic  por_reset;
    logic  test_reset;
    logic  reset;
    logic  clear_dmem;
    word_t address_imem;
    word_t q_imem;
    word_t address_dmem;
    word_t data;
    logic  wren;
    word_t q_dmem;

    word_t imem [0:MEM_WORDS-1] = '{default: '0};
    word_t dmem [0:MEM_WORDS-1] = '{default: '0};

    word_t seen_addr [$];
    word_t seen_data [$];
    word_t exp_addr [$];
    word_t exp_data [$];

    logic        recording;
    int          load_ptr;
    string       test_name;
    logic [31:0] rng_state;
    int          test_errors;
    int          total_errors;
    int          tests_failed;

    assign reset = por_reset || test_reset;

    cpu_clock_gen u_clock_gen (
        .clock (clock),
        .reset (por_reset)
    );

    pipeline_cpu u_dut (
        .clock        (clock),
        .reset        (reset),
        .address_imem (address_imem),
        .q_imem       (q_imem),
        .address_dmem (address_dmem),
        .data         (data),
        .wren         (wren),
        .q_dmem       (q_dmem)
    );

    // Word addressed with zero read back past the top
    assign q_imem = (address_imem < MEM_WORDS) ? imem[address_imem[7:0]] : '0;
    assign q_dmem = (address_dmem < MEM_WORDS) ? dmem[address_dmem[7:0]] : '0;

    always @(posedge clock) begin
        int i;
        if (clear_dmem) begin
            for (i = 0; i < MEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (wren === 1'b1 && address_dmem < MEM_WORDS) begin
            dmem[address_dmem[7:0]] <= data;
        end
    end

    // Sampled mid-cycle where the store outputs are settled
    always @(negedge clock) begin
        if (recording && wren === 1'b1) begin
            seen_addr.push_back(address_dmem);
            seen_data.push_back(data);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t sext17(input logic [16:0] v);
        return {{15{v[16]}}, v};
    endfunction

    function automatic word_t r_type(input alu_op_t f, input reg_addr_t rd, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [4:0] sh);
        return {`CPU_OP_RTYPE, rd, rs, rt, sh, f, 2'b00};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rd,
                                     input reg_addr_t rs, input int imm);
        word_t v;
        v = imm;
        return {op, rd, rs, v[16:0]};
    endfunction

    function automatic word_t j_type(input opcode_t op, input int target);
        word_t v;
        v = target;
        return {op, v[26:0]};
    endfunction

    task automatic emit(input word_t w);
        imem[load_ptr] <= w;
        load_ptr++;
    endtask

    task automatic expect_store(input word_t a, input word_t d);
        exp_addr.push_back(a);
        exp_data.push_back(d);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("** Error: %s = %h, expected %h", name, got, want);
            test_errors++;
        end
    endtask

    `include "cpu_programs.svh"

    task automatic run_test(input int idx);
        int cycles;
        int i;
        @(posedge clock);
        recording = 1'b0;
        for (i = 0; i < MEM_WORDS; i++) begin
            imem[i] <= '0;
        end
        exp_addr.delete();
        exp_data.delete();
        load_ptr = 0;
        load_entry(idx);
        clear_dmem <= 1'b1;
        test_reset <= 1'b1;
        repeat (3) @(posedge clock);
        clear_dmem <= 1'b0;
        test_reset <= 1'b0;
        seen_addr.delete();
        seen_data.delete();
        test_errors = 0;
        recording = 1'b1;

        // Fetch starts at zero and nothing has reached memory yet
        @(negedge clock);
        check_value("wren", word_t'(wren), '0);
        check_value("address_imem", address_imem, '0);

        cycles = 0;
        while (seen_addr.size() < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (seen_addr.size() < exp_addr.size()) begin
            $display("%s: timed out after %0d cycles with %0d of %0d stores seen",
                     test_name, STORE_TIMEOUT, seen_addr.size(), exp_addr.size());
            test_errors++;
        end

        // Any extra store shows up during the drain
        cycles = 0;
        while (cycles < DRAIN_CYCLES) begin
            @(posedge clock);
            cycles++;
        end
        recording = 1'b0;

        if (seen_addr.size() > exp_addr.size()) begin
            $display("%s: %0d stores seen but only %0d expected",
                     test_name, seen_addr.size(), exp_addr.size());
            test_errors++;
        end
        for (i = 0; i < exp_addr.size() && i < seen_addr.size(); i++) begin
            check_value($sformatf("store %0d address_dmem", i), seen_addr[i], exp_addr[i]);
            check_value($sformatf("store %0d data", i), seen_data[i], exp_data[i]);
        end

        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d %s: %s", idx, test_name, (test_errors == 0) ? "pass" : "fail");
    endtask

    initial begin
        int t;
        test_reset   = 1'b0;
        clear_dmem   = 1'b0;
        recording    = 1'b0;
        load_ptr     = 0;
        rng_state    = 32'hbb4c2dbe;
        total_errors = 0;
        tests_failed = 0;
        for (t = 0; t < NUM_ENTRIES; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d failed, %0d errors", NUM_ENTRIES, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* pipeline_cpu.f */
+incdir+hdl
+incdir+tb
hdl/cpu_pkg.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/pipeline_cpu.sv
tb/cpu_clock_gen.sv
tb/cpu_tb.sv

/* Bender.yml */
package:
  name: pipeline_cpu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu_pkg.sv
      - hdl/reg_file.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/hazard_unit.sv
      - hdl/execute_stage.sv
      - hdl/memory_stage.sv
      - hdl/pipeline_cpu.sv
  - target: simulation
    include_dirs:
      - hdl
      - tb
    files:
      - tb/cpu_clock_gen.sv
      - tb/cpu_tb.sv
